// ==== design/fifo_defs.svh ====
// dual-clock FIFO sizing macros shared by the package and every RTL block

`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

////////////////////////////////////////
// data path
////////////////////////////////////////

// bits per stored word
`define FIFO_DATA_WIDTH 32

////////////////////////////////////////
// storage and pointers
////////////////////////////////////////

// number of entries, a power of two and at least 2
`define FIFO_DEPTH 8

// base-2 log of the depth
`define FIFO_ADDR_WIDTH 3

// flops per clock domain crossing
`define FIFO_SYNC_STAGES 2

`endif

// ==== design/fifo_pkg.sv ====
// dual-clock FIFO types for words, entry indices, pointers and the write port

`include "fifo_defs.svh"

package fifo_pkg;

	////////////////////////////////////////
	// basic vectors
	////////////////////////////////////////

	// one data word as seen on both ports
	typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;

	// index into the entry array
	typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_addr_t;

	// binary pointer with a wrap bit above the address
	typedef logic [`FIFO_ADDR_WIDTH:0] fifo_ptr_t;

	// gray coded pointer, the only form allowed across domains
	typedef logic [`FIFO_ADDR_WIDTH:0] gray_ptr_t;

	////////////////////////////////////////
	// write port into storage
	////////////////////////////////////////

	// one accepted write, strobe high only in the accepting cycle
	typedef struct packed {
		logic       strobe;
		fifo_addr_t addr;
		fifo_data_t data;
	} write_port_t;

endpackage

// ==== design/cdc_sync.sv ====
// multi-flop synchronizer for pointers and reset, clears to a chosen value

`timescale 1ns/1ps

`include "fifo_defs.svh"

module cdc_sync #(
	parameter int WIDTH = 1,
	parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [WIDTH-1:0] data_in,
	output logic [WIDTH-1:0] data_out
);

	// stage 0 samples the foreign domain, last stage is safe to use
	logic [`FIFO_SYNC_STAGES-1:0][WIDTH-1:0] sync_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// every stage back to the idle value
			sync_q <= {`FIFO_SYNC_STAGES{RESET_VALUE}};
		end
		else
		begin
			// shift one stage per clock
			sync_q <= {sync_q[`FIFO_SYNC_STAGES-2:0], data_in};
		end
	end

	assign data_out = sync_q[`FIFO_SYNC_STAGES-1];

endmodule

// ==== design/write_ptr_ctrl.sv ====
// write side control with gray write pointer, read pointer sync and full flag

`timescale 1ns/1ps

`include "fifo_defs.svh"

module write_ptr_ctrl import fifo_pkg::*; (
	input  logic        write_clk,
	input  logic        reset_rsync,
	input  logic        write_en,
	input  fifo_data_t  write_data,
	input  gray_ptr_t   read_gray,
	output gray_ptr_t   write_gray,
	output write_port_t wr_port,
	output logic        full
);

	// full when the two top gray bits differ and the rest agree
	localparam gray_ptr_t FULL_MASK = gray_ptr_t'(3) << (`FIFO_ADDR_WIDTH - 1);

	////////////////////////////////////////
	// pointer state
	////////////////////////////////////////

	// binary copy drives the entry address
	fifo_ptr_t write_bin;
	fifo_ptr_t write_bin_next;
	// gray copy is what the read side sees
	gray_ptr_t write_gray_next;
	// read pointer after crossing into write_clk
	gray_ptr_t read_gray_sync;
	logic      write_accept;

	////////////////////////////////////////
	// read pointer crossing
	////////////////////////////////////////

	cdc_sync #(
		.WIDTH($bits(gray_ptr_t)),
		.RESET_VALUE('0)
	) i_read_gray_sync (
		.clk(write_clk),
		.reset(reset_rsync),
		.data_in(read_gray),
		.data_out(read_gray_sync)
	);

	// compare against the current pointers, no extra register stage
	assign full = ((write_gray ^ read_gray_sync) == FULL_MASK);

	// a write while full is dropped here
	assign write_accept = write_en && !full;

	////////////////////////////////////////
	// pointer advance
	////////////////////////////////////////

	assign write_bin_next  = write_bin + 1'b1;
	// binary to gray
	assign write_gray_next = write_bin_next ^ (write_bin_next >> 1);

	always_ff @(posedge write_clk)
	begin
		if (reset_rsync)
		begin
			write_bin  <= '0;
			write_gray <= '0;
		end
		else if (write_accept)
		begin
			// both forms move on the same edge
			write_bin  <= write_bin_next;
			write_gray <= write_gray_next;
		end
	end

	// word goes to storage at the accepting edge
	assign wr_port.strobe = write_accept;
	// low bits of the pointer select the entry
	assign wr_port.addr   = write_bin[`FIFO_ADDR_WIDTH-1:0];
	assign wr_port.data   = write_data;

endmodule

// ==== design/read_ptr_ctrl.sv ====
// read side control with reset sync, gray read pointer and empty flag

`timescale 1ns/1ps

`include "fifo_defs.svh"

module read_ptr_ctrl import fifo_pkg::*; (
	input  logic       read_clk,
	input  logic       reset_rsync,
	input  logic       read_en,
	input  gray_ptr_t  write_gray,
	output gray_ptr_t  read_gray,
	output logic       read_strobe,
	output fifo_addr_t read_addr,
	output logic       read_reset,
	output logic       empty
);

	////////////////////////////////////////
	// pointer state
	////////////////////////////////////////

	// binary copy addresses storage
	fifo_ptr_t read_bin;
	fifo_ptr_t read_bin_next;
	gray_ptr_t read_gray_next;
	// write pointer after crossing into read_clk
	gray_ptr_t write_gray_sync;

	////////////////////////////////////////
	// read domain reset
	////////////////////////////////////////

	// held in reset until the release has walked through every stage
	cdc_sync #(
		.WIDTH(1),
		.RESET_VALUE(1'b1)
	) i_read_reset_sync (
		.clk(read_clk),
		.reset(reset_rsync),
		.data_in(1'b0),
		.data_out(read_reset)
	);

	////////////////////////////////////////
	// write pointer crossing
	////////////////////////////////////////

	cdc_sync #(
		.WIDTH($bits(gray_ptr_t)),
		.RESET_VALUE('0)
	) i_write_gray_sync (
		.clk(read_clk),
		.reset(read_reset),
		.data_in(write_gray),
		.data_out(write_gray_sync)
	);

	// nothing new once the pointers meet
	assign empty = (write_gray_sync == read_gray);

	// a read while empty does nothing
	assign read_strobe = read_en && !empty;

	// entry for the pop is the current pointer
	assign read_addr = read_bin[`FIFO_ADDR_WIDTH-1:0];

	////////////////////////////////////////
	// pointer advance
	////////////////////////////////////////

	assign read_bin_next  = read_bin + 1'b1;
	assign read_gray_next = read_bin_next ^ (read_bin_next >> 1);

	always_ff @(posedge read_clk)
	begin
		if (read_reset)
		begin
			read_bin  <= '0;
			read_gray <= '0;
		end
		else if (read_strobe)
		begin
			// freed slot shows up on the write side a few edges later
			read_bin  <= read_bin_next;
			read_gray <= read_gray_next;
		end
	end

endmodule

// ==== design/fifo_storage.sv ====
// FIFO entry array, written on write_clk and popped into a read_clk register

`timescale 1ns/1ps

`include "fifo_defs.svh"

module fifo_storage import fifo_pkg::*; (
	input  logic        write_clk,
	input  logic        read_clk,
	input  logic        read_reset,
	input  write_port_t wr_port,
	input  logic        read_strobe,
	input  fifo_addr_t  read_addr,
	output fifo_data_t  read_data
);

	// one word per entry
	fifo_data_t mem [`FIFO_DEPTH];

	////////////////////////////////////////
	// write_clk side
	////////////////////////////////////////

	always_ff @(posedge write_clk)
	begin
		// only accepted writes arrive with the strobe set
		if (wr_port.strobe)
		begin
			mem[wr_port.addr] <= wr_port.data;
		end
	end

	////////////////////////////////////////
	// read_clk side
	////////////////////////////////////////

	always_ff @(posedge read_clk)
	begin
		if (read_reset)
		begin
			read_data <= '0;
		end
		else if (read_strobe)
		begin
			// holds until the next accepted read
			read_data <= mem[read_addr];
		end
	end

endmodule

// ==== design/async_fifo.sv ====
// dual-clock FIFO top joining write control, read control and storage

`timescale 1ns/1ps

`include "fifo_defs.svh"

module async_fifo import fifo_pkg::*; (
	input  logic       write_clk,
	input  logic       read_clk,
	input  logic       reset_rsync,
	input  logic       write_en,
	input  fifo_data_t write_data,
	output logic       full,
	input  logic       read_en,
	output logic       empty,
	output fifo_data_t read_data
);

	// gray pointers crossing between the domains
	gray_ptr_t   write_gray;
	gray_ptr_t   read_gray;
	// accepted write into the array
	write_port_t wr_port;
	// pop request and reset on the read side
	logic        read_strobe;
	fifo_addr_t  read_addr;
	logic        read_reset;

	////////////////////////////////////////
	// write_clk domain
	////////////////////////////////////////

	write_ptr_ctrl i_write_ptr_ctrl (
		.write_clk(write_clk),
		.reset_rsync(reset_rsync),
		.write_en(write_en),
		.write_data(write_data),
		.read_gray(read_gray),
		.write_gray(write_gray),
		.wr_port(wr_port),
		.full(full)
	);

	////////////////////////////////////////
	// read_clk domain
	////////////////////////////////////////

	read_ptr_ctrl i_read_ptr_ctrl (
		.read_clk(read_clk),
		.reset_rsync(reset_rsync),
		.read_en(read_en),
		.write_gray(write_gray),
		.read_gray(read_gray),
		.read_strobe(read_strobe),
		.read_addr(read_addr),
		.read_reset(read_reset),
		.empty(empty)
	);

	// array sits between both domains
	fifo_storage i_fifo_storage (
		.write_clk(write_clk),
		.read_clk(read_clk),
		.read_reset(read_reset),
		.wr_port(wr_port),
		.read_strobe(read_strobe),
		.read_addr(read_addr),
		.read_data(read_data)
	);

endmodule

// ==== dv/async_fifo_tb.sv ====
// dual-clock FIFO testbench with a queue model, directed and random traffic

`timescale 1ns/1ps

`include "fifo_defs.svh"

module async_fifo_tb import fifo_pkg::*; ();

	// write_clk cycles before the run counts as hung, well above all phases together
	localparam int TIMEOUT_CYCLES = 6000;
	// length of the random phase in write_clk cycles
	localparam int RANDOM_CYCLES = 400;
	localparam logic [31:0] LCG_SEED = 32'h09ae_bf61;

	logic       write_clk;
	logic       read_clk;
	logic       reset_rsync;
	logic       write_en;
	fifo_data_t write_data;
	logic       full;
	logic       read_en;
	logic       empty;
	fifo_data_t read_data;

	// words accepted on the write side and not popped yet
	fifo_data_t  model[$];
	fifo_data_t  pending_word;
	logic [31:0] lcg_state;
	// random read thread keeps going while this is set
	logic        traffic_on;
	int          error_count;
	int          check_count;
	int          cycle_count;

	async_fifo i_async_fifo (
		.write_clk(write_clk),
		.read_clk(read_clk),
		.reset_rsync(reset_rsync),
		.write_en(write_en),
		.write_data(write_data),
		.full(full),
		.read_en(read_en),
		.empty(empty),
		.read_data(read_data)
	);

	////////////////////////////////////////
	// clocks
	////////////////////////////////////////

	initial
	begin
		write_clk = 1'b0;
		forever #50 write_clk = ~write_clk;
	end

	// 130 ns with a small offset so no edge lines up with a write_clk edge
	initial
	begin
		read_clk = 1'b0;
		#7;
		forever #65 read_clk = ~read_clk;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] next_random();
		// 32-bit LCG, full period
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// oldest word of the model, taken out
	function automatic fifo_data_t expected_word();
		fifo_data_t word;
		if (model.size() == 0)
		begin
			$display("read accepted at %0t while the model holds no word", $time);
			error_count++;
			word = '0;
		end
		else
		begin
			word = model.pop_front();
		end
		return word;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
		begin
			$display("Done: no errors");
		end
		else
		begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	task automatic apply_reset();
		@(negedge write_clk);
		reset_rsync = 1'b1;
		repeat (16) @(negedge write_clk);
		reset_rsync = 1'b0;
	endtask

	// idle state once both domains are out of reset
	task automatic check_reset_state();
		// read side needs FIFO_SYNC_STAGES edges to let go
		repeat (`FIFO_SYNC_STAGES + 2) @(negedge read_clk);
		check_value("empty", 32'(empty), 32'd1);
		check_value("read_data", read_data, 32'd0);
		@(negedge write_clk);
		check_value("full", 32'(full), 32'd0);
	endtask

	task automatic push_word(input fifo_data_t word);
		@(negedge write_clk);
		write_en   = 1'b1;
		write_data = word;
		@(negedge write_clk);
		write_en   = 1'b0;
	endtask

	task automatic wait_not_empty();
		int waited;
		waited = 0;
		@(negedge read_clk);
		while (empty && waited < 16)
		begin
			@(negedge read_clk);
			waited++;
		end
		if (empty)
		begin
			$display("empty stayed high for 16 read_clk cycles with data written");
			error_count++;
		end
	endtask

	// empty only moves on read_clk rising edges, so this pop is taken
	task automatic pop_word();
		wait_not_empty();
		read_en = 1'b1;
		@(negedge read_clk);
		read_en = 1'b0;
	endtask

	task automatic random_writes(input int cycles);
		logic [31:0] rnd;
		repeat (cycles)
		begin
			@(negedge write_clk);
			rnd = next_random();
			// top bits of an LCG are the good ones
			write_en   = rnd[31];
			write_data = next_random();
		end
		@(negedge write_clk);
		write_en = 1'b0;
	endtask

	task automatic random_reads();
		logic [31:0] rnd;
		while (traffic_on)
		begin
			@(negedge read_clk);
			rnd = next_random();
			read_en = rnd[30];
		end
		@(negedge read_clk);
		read_en = 1'b0;
	endtask

	// pop until empty has stayed high for a while, then nothing may be left
	task automatic drain_fifo();
		int idle_cycles;
		idle_cycles = 0;
		while (idle_cycles < 8)
		begin
			@(negedge read_clk);
			read_en = !empty;
			if (empty)
			begin
				idle_cycles++;
			end
			else
			begin
				idle_cycles = 0;
			end
		end
		read_en = 1'b0;
		check_value("model size", model.size(), 32'd0);
	endtask

	////////////////////////////////////////
	// model and compare
	////////////////////////////////////////

	// values before the edge are what the DUT acts on
	always @(posedge write_clk)
	begin
		if (reset_rsync)
		begin
			model.delete();
		end
		else if (write_en && !full)
		begin
			model.push_back(write_data);
		end
	end

	// take the expected word at the pop, compare once read_data has settled
	always @(posedge read_clk)
	begin
		if (!reset_rsync && read_en && !empty)
		begin
			pending_word = expected_word();
			@(negedge read_clk);
			check_value("read_data", read_data, pending_word);
		end
	end

	always @(posedge write_clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout, run still going after %0d write_clk cycles", TIMEOUT_CYCLES);
			error_count++;
			finish_run();
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		int i;
		reset_rsync = 1'b1;
		write_en    = 1'b0;
		write_data  = '0;
		read_en     = 1'b0;
		traffic_on  = 1'b0;
		lcg_state   = LCG_SEED;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;

		// flags and read_data right after reset
		apply_reset();
		check_reset_state();

		// five words come back in order
		for (i = 0; i < 5; i++)
		begin
			push_word(fifo_data_t'(32'hc0de_0000 + i));
		end
		for (i = 0; i < 5; i++)
		begin
			pop_word();
		end
		repeat (4) @(negedge read_clk);
		check_value("empty", 32'(empty), 32'd1);

		// freed slots need a few write_clk edges to show up
		repeat (4) @(negedge write_clk);
		check_value("full", 32'(full), 32'd0);

		// fill with reads idle, one write more than fits
		for (i = 0; i <= `FIFO_DEPTH; i++)
		begin
			push_word(fifo_data_t'(32'hf111_0000 + i));
			check_value("full", 32'(full), (i + 1 >= `FIFO_DEPTH) ? 32'd1 : 32'd0);
		end
		check_value("model size", model.size(), `FIFO_DEPTH);
		for (i = 0; i < `FIFO_DEPTH; i++)
		begin
			pop_word();
		end
		repeat (6) @(negedge read_clk);
		// a stored ninth word would keep empty low here
		check_value("empty", 32'(empty), 32'd1);
		repeat (4) @(negedge write_clk);
		check_value("full", 32'(full), 32'd0);

		// reads on an empty FIFO keep the last popped word
		check_value("empty", 32'(empty), 32'd1);
		@(negedge read_clk);
		read_en = 1'b1;
		repeat (4)
		begin
			@(negedge read_clk);
			check_value("read_data", read_data,
				fifo_data_t'(32'hf111_0000 + `FIFO_DEPTH - 1));
		end
		read_en = 1'b0;

		// random traffic on both sides
		traffic_on = 1'b1;
		fork
			begin
				random_writes(RANDOM_CYCLES);
				traffic_on = 1'b0;
			end
			random_reads();
		join
		drain_fifo();

		// reset lands while both sides are busy
		traffic_on = 1'b1;
		fork
			begin
				random_writes(40);
				traffic_on = 1'b0;
			end
			random_reads();
			begin
				repeat (30) @(negedge write_clk);
				apply_reset();
			end
		join
		check_reset_state();

		// one word through after the reset
		push_word(32'h5eed_0001);
		pop_word();
		repeat (4) @(negedge read_clk);
		check_value("read_data", read_data, 32'h5eed_0001);
		check_value("empty", 32'(empty), 32'd1);

		finish_run();
	end

endmodule

// ==== async_fifo.f ====
+incdir+design
design/fifo_pkg.sv
design/cdc_sync.sv
design/write_ptr_ctrl.sv
design/read_ptr_ctrl.sv
design/fifo_storage.sv
design/async_fifo.sv
dv/async_fifo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the dual-clock FIFO testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f async_fifo.f --top-module async_fifo_tb -o sim_async_fifo

output=$(./obj_dir/sim_async_fifo)
echo "$output"

if echo "$output" | grep -q "^Done: no errors$"; then
	exit 0
else
	exit 1
fi
